// File: design/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int ROB_DEPTH    = 8;
    localparam int ALU_RS_DEPTH = 4;
    localparam int MUL_RS_DEPTH = 2;
    localparam int BR_RS_DEPTH  = 2;
    localparam int MEM_RS_DEPTH = 4;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  rob_idx_t;
    typedef logic [1:0]  op_class_t;
    typedef logic [3:0]  op_code_t;

    // operation classes, also the fu_ready bit positions
    localparam op_class_t OPC_ALU = 2'd0;
    localparam op_class_t OPC_MUL = 2'd1;
    localparam op_class_t OPC_BR  = 2'd2;
    localparam op_class_t OPC_MEM = 2'd3;

    typedef struct packed {
        logic      valid;
        op_class_t op_class;
        op_code_t  op;
        reg_addr_t rd_addr;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        rob_idx_t  rd_rob_idx;
        rob_idx_t  rs1_rob_idx;
        rob_idx_t  rs2_rob_idx;
        word_t     imm;
        logic      use_imm;
    } dispatch_pkt_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        word_t    data;
    } cdb_port_t;

    typedef struct packed {
        cdb_port_t alu;
        cdb_port_t mul;
        cdb_port_t mem;
    } cdb_t;

    // station slot, same layout goes out on issue
    typedef struct packed {
        logic      valid;
        op_class_t op_class;
        op_code_t  op;
        rob_idx_t  rd_rob_idx;
        rob_idx_t  rs1_tag;
        logic      rs1_ready;
        word_t     rs1_data;
        rob_idx_t  rs2_tag;
        logic      rs2_ready;
        word_t     rs2_data;
        word_t     imm;
        logic      use_imm;
    } rs_entry_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } rob_result_t;

    // first broadcasting port carrying this tag, alu before mul before mem
    function automatic cdb_port_t cdb_match(input cdb_t c, input rob_idx_t tag);
        cdb_port_t m;
        m = '0;
        if (c.alu.valid && c.alu.rob_idx == tag) begin
            m = c.alu;
        end else if (c.mul.valid && c.mul.rob_idx == tag) begin
            m = c.mul;
        end else if (c.mem.valid && c.mem.rob_idx == tag) begin
            m = c.mem;
        end
        return m;
    endfunction

endpackage

`default_nettype wire

// File: design/rob_result_table.sv
`default_nettype none
`timescale 1ns/1ps

module rob_result_table (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::cdb_t       cdb,
    input  logic                alloc_valid,
    input  ooo_pkg::rob_idx_t   alloc_rob_idx,
    input  logic                commit_valid,
    input  ooo_pkg::rob_idx_t   commit_rob_idx,
    output ooo_pkg::rob_result_t rob_results [ooo_pkg::ROB_DEPTH]
);
    import ooo_pkg::*;

    logic [ROB_DEPTH-1:0] valid_q;
    word_t                data_q [ROB_DEPTH];
    cdb_port_t            wr     [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] clr;

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            wr[i]  = cdb_match(cdb, rob_idx_t'(i));
            clr[i] = (alloc_valid && alloc_rob_idx == rob_idx_t'(i)) ||
                     (commit_valid && commit_rob_idx == rob_idx_t'(i));
        end
    end

    // a writeback wins over a clear of the same tag
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (wr[i].valid) begin
                    valid_q[i] <= 1'b1;
                end else if (clr[i]) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (wr[i].valid) begin
                data_q[i] <= wr[i].data;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_results[i].valid = valid_q[i];
            rob_results[i].data  = data_q[i];
        end
    end

endmodule

`default_nettype wire

// File: design/reservation_station.sv
`default_nettype none
`timescale 1ns/1ps

module reservation_station #(
    parameter int DEPTH    = 4,
    parameter bit IN_ORDER = 1'b0
) (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::rs_entry_t new_entry,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               fu_ready,
    output logic               full,
    output ooo_pkg::rs_entry_t next_issue
);
    import ooo_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    rs_entry_t        slots   [DEPTH];
    rs_entry_t        slots_n [DEPTH];
    rs_entry_t        woken   [DEPTH];
    logic [DEPTH-1:0] occupied;
    logic             sel_found;
    logic [IDX_W-1:0] sel_idx;
    logic             hold_q;
    logic [IDX_W-1:0] hold_idx_q;
    logic             issue_fire;
    int               tail;

    function automatic rs_entry_t wake(input rs_entry_t e, input cdb_t c);
        rs_entry_t r;
        cdb_port_t m1;
        cdb_port_t m2;
        r  = e;
        m1 = cdb_match(c, e.rs1_tag);
        m2 = cdb_match(c, e.rs2_tag);
        if (!e.rs1_ready && m1.valid) begin
            r.rs1_ready = 1'b1;
            r.rs1_data  = m1.data;
        end
        if (!e.rs2_ready && m2.valid) begin
            r.rs2_ready = 1'b1;
            r.rs2_data  = m2.data;
        end
        return r;
    endfunction

    function automatic logic is_ready(input rs_entry_t e);
        return e.valid && e.rs1_ready && e.rs2_ready;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            occupied[i] = slots[i].valid;
        end
    end

    assign full = &occupied;

    // keep the presented slot while the unit stalls
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        if (hold_q) begin
            sel_found = 1'b1;
            sel_idx   = hold_idx_q;
        end else if (IN_ORDER) begin
            sel_found = is_ready(slots[0]);
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (!sel_found && is_ready(slots[i])) begin
                    sel_found = 1'b1;
                    sel_idx   = IDX_W'(i);
                end
            end
        end
    end

    assign next_issue = sel_found ? slots[sel_idx] : '0;
    assign issue_fire = sel_found && fu_ready;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woken[i] = wake(slots[i], cdb);
        end
        slots_n = woken;
        // collapse younger slots over the issued one
        if (issue_fire) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                if (i >= int'(sel_idx)) begin
                    slots_n[i] = woken[i + 1];
                end
            end
            slots_n[DEPTH - 1].valid = 1'b0;
        end
        tail = DEPTH;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!slots_n[i].valid) begin
                tail = i;
            end
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (new_entry.valid && i == tail) begin
                slots_n[i] = wake(new_entry, cdb);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i].valid <= 1'b0;
            end
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            slots      <= slots_n;
            hold_q     <= sel_found && !fu_ready;
            hold_idx_q <= sel_idx;
        end
    end

endmodule

`default_nettype wire

// File: design/dispatch_issue.sv
`default_nettype none
`timescale 1ns/1ps

module dispatch_issue (
    input  logic                  clk,
    input  logic                  rst,
    input  ooo_pkg::dispatch_pkt_t dispatch,
    input  ooo_pkg::word_t        rs1_data,
    input  logic                  rs1_ready,
    input  ooo_pkg::word_t        rs2_data,
    input  logic                  rs2_ready,
    input  ooo_pkg::cdb_t         cdb,
    input  ooo_pkg::rob_result_t  rob_results [ooo_pkg::ROB_DEPTH],
    input  logic [3:0]            fu_ready,
    output logic                  dispatch_stall,
    output logic                  accept,
    output ooo_pkg::rs_entry_t    issue_alu,
    output ooo_pkg::rs_entry_t    issue_mul,
    output ooo_pkg::rs_entry_t    issue_br,
    output ooo_pkg::rs_entry_t    issue_mem
);
    import ooo_pkg::*;

    rs_entry_t  entry;
    rs_entry_t  station_in [4];
    logic [3:0] full;
    word_t      op1_data;
    word_t      op2_data;
    logic       op1_ready;
    logic       op2_ready;

    // register file, then ROB table, then a same-cycle broadcast
    function automatic logic capture(
        input  logic        rf_ready,
        input  word_t       rf_data,
        input  rob_result_t rob_entry,
        input  cdb_port_t   bcast,
        output word_t       data
    );
        data = '0;
        if (rf_ready) begin
            data = rf_data;
            return 1'b1;
        end
        if (rob_entry.valid) begin
            data = rob_entry.data;
            return 1'b1;
        end
        if (bcast.valid) begin
            data = bcast.data;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    always_comb begin
        op1_ready = capture(rs1_ready, rs1_data, rob_results[dispatch.rs1_rob_idx],
                            cdb_match(cdb, dispatch.rs1_rob_idx), op1_data);
        op2_ready = capture(rs2_ready, rs2_data, rob_results[dispatch.rs2_rob_idx],
                            cdb_match(cdb, dispatch.rs2_rob_idx), op2_data);
    end

    always_comb begin
        entry            = '0;
        entry.valid      = dispatch.valid;
        entry.op_class   = dispatch.op_class;
        entry.op         = dispatch.op;
        entry.rd_rob_idx = dispatch.rd_rob_idx;
        entry.rs1_tag    = dispatch.rs1_rob_idx;
        entry.rs1_ready  = op1_ready;
        entry.rs1_data   = op1_data;
        entry.rs2_tag    = dispatch.rs2_rob_idx;
        entry.rs2_ready  = op2_ready;
        entry.rs2_data   = op2_data;
        entry.imm        = dispatch.imm;
        entry.use_imm    = dispatch.use_imm;
    end

    assign dispatch_stall = dispatch.valid && full[dispatch.op_class];
    assign accept         = dispatch.valid && !full[dispatch.op_class];

    // only the target station sees the entry
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            station_in[c] = '0;
            if (accept && dispatch.op_class == op_class_t'(c)) begin
                station_in[c] = entry;
            end
        end
    end

    reservation_station #(.DEPTH(ALU_RS_DEPTH)) alu_rs (
        .clk        (clk),
        .rst        (rst),
        .new_entry  (station_in[OPC_ALU]),
        .cdb        (cdb),
        .fu_ready   (fu_ready[OPC_ALU]),
        .full       (full[OPC_ALU]),
        .next_issue (issue_alu)
    );

    reservation_station #(.DEPTH(MUL_RS_DEPTH)) mul_rs (
        .clk        (clk),
        .rst        (rst),
        .new_entry  (station_in[OPC_MUL]),
        .cdb        (cdb),
        .fu_ready   (fu_ready[OPC_MUL]),
        .full       (full[OPC_MUL]),
        .next_issue (issue_mul)
    );

    reservation_station #(.DEPTH(BR_RS_DEPTH)) br_rs (
        .clk        (clk),
        .rst        (rst),
        .new_entry  (station_in[OPC_BR]),
        .cdb        (cdb),
        .fu_ready   (fu_ready[OPC_BR]),
        .full       (full[OPC_BR]),
        .next_issue (issue_br)
    );

    // memory ops leave strictly in program order
    reservation_station #(.DEPTH(MEM_RS_DEPTH), .IN_ORDER(1'b1)) mem_rs (
        .clk        (clk),
        .rst        (rst),
        .new_entry  (station_in[OPC_MEM]),
        .cdb        (cdb),
        .fu_ready   (fu_ready[OPC_MEM]),
        .full       (full[OPC_MEM]),
        .next_issue (issue_mem)
    );

endmodule

`default_nettype wire

// File: design/issue_top.sv
`default_nettype none
`timescale 1ns/1ps

module issue_top (
    input  logic                   clk,
    input  logic                   rst,
    input  ooo_pkg::dispatch_pkt_t dispatch,
    input  ooo_pkg::word_t         rs1_data,
    input  logic                   rs1_ready,
    input  ooo_pkg::word_t         rs2_data,
    input  logic                   rs2_ready,
    input  ooo_pkg::cdb_t          cdb,
    input  logic                   commit_valid,
    input  ooo_pkg::rob_idx_t      commit_rob_idx,
    input  logic [3:0]             fu_ready,
    output logic                   dispatch_stall,
    output ooo_pkg::rs_entry_t     issue_alu,
    output ooo_pkg::rs_entry_t     issue_mul,
    output ooo_pkg::rs_entry_t     issue_br,
    output ooo_pkg::rs_entry_t     issue_mem
);
    import ooo_pkg::*;

    rob_result_t rob_results [ROB_DEPTH];
    logic        accept;

    dispatch_issue u_dispatch (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .rs1_data       (rs1_data),
        .rs1_ready      (rs1_ready),
        .rs2_data       (rs2_data),
        .rs2_ready      (rs2_ready),
        .cdb            (cdb),
        .rob_results    (rob_results),
        .fu_ready       (fu_ready),
        .dispatch_stall (dispatch_stall),
        .accept         (accept),
        .issue_alu      (issue_alu),
        .issue_mul      (issue_mul),
        .issue_br       (issue_br),
        .issue_mem      (issue_mem)
    );

    // an accepted dispatch owns its rd tag from here on
    rob_result_table u_rob_table (
        .clk            (clk),
        .rst            (rst),
        .cdb            (cdb),
        .alloc_valid    (accept),
        .alloc_rob_idx  (dispatch.rd_rob_idx),
        .commit_valid   (commit_valid),
        .commit_rob_idx (commit_rob_idx),
        .rob_results    (rob_results)
    );

endmodule

`default_nettype wire

// File: tests/issue_assert.sv
`default_nettype none
`timescale 1ns/1ps

module issue_assert (
    input logic                   clk,
    input logic                   rst,
    input ooo_pkg::dispatch_pkt_t dispatch,
    input logic [3:0]             fu_ready,
    input logic                   dispatch_stall,
    input ooo_pkg::rs_entry_t     issue_alu,
    input ooo_pkg::rs_entry_t     issue_mul,
    input ooo_pkg::rs_entry_t     issue_br,
    input ooo_pkg::rs_entry_t     issue_mem
);
    import ooo_pkg::*;

    // nothing leaves a station with a missing operand
    a_alu_ready: assert property (@(posedge clk) disable iff (rst)
        issue_alu.valid |-> issue_alu.rs1_ready && issue_alu.rs2_ready) else $error("alu");
    a_mul_ready: assert property (@(posedge clk) disable iff (rst)
        issue_mul.valid |-> issue_mul.rs1_ready && issue_mul.rs2_ready) else $error("mul");
    a_br_ready: assert property (@(posedge clk) disable iff (rst)
        issue_br.valid |-> issue_br.rs1_ready && issue_br.rs2_ready) else $error("br");
    a_mem_ready: assert property (@(posedge clk) disable iff (rst)
        issue_mem.valid |-> issue_mem.rs1_ready && issue_mem.rs2_ready) else $error("mem");

    a_stall_valid: assert property (@(posedge clk) disable iff (rst)
        dispatch_stall |-> dispatch.valid) else $error("stall without dispatch");

    a_reset_quiet: assert property (@(posedge clk)
        $past(rst) && !rst |-> !issue_alu.valid && !issue_mul.valid && !issue_br.valid &&
        !issue_mem.valid && !dispatch_stall) else $error("outputs active after reset");

    // held issue output under back-pressure
    a_alu_hold: assert property (@(posedge clk) disable iff (rst)
        issue_alu.valid && !fu_ready[0] |=> $stable(issue_alu)) else $error("alu hold");
    a_mul_hold: assert property (@(posedge clk) disable iff (rst)
        issue_mul.valid && !fu_ready[1] |=> $stable(issue_mul)) else $error("mul hold");
    a_br_hold: assert property (@(posedge clk) disable iff (rst)
        issue_br.valid && !fu_ready[2] |=> $stable(issue_br)) else $error("br hold");
    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        issue_mem.valid && !fu_ready[3] |=> $stable(issue_mem)) else $error("mem hold");

endmodule

bind issue_top issue_assert u_assert (.*);

`default_nettype wire

// File: tests/issue_tb.sv
`default_nettype none
`timescale 1ns/1ps

module issue_tb;
    import ooo_pkg::*;

    localparam int MAX_IDS   = 512;
    localparam int RAND_OPS  = 150;
    // cycle budgets of the six tests
    localparam int RUN_LIMIT = 4 * (20 + 40 + 60 + 60 + 60 + RAND_OPS * 10);

    logic          clk;
    logic          rst;
    dispatch_pkt_t dispatch;
    word_t         rs1_data;
    logic          rs1_ready;
    word_t         rs2_data;
    logic          rs2_ready;
    cdb_t          cdb;
    logic          commit_valid;
    rob_idx_t      commit_rob_idx;
    logic [3:0]    fu_ready;
    logic          dispatch_stall;
    rs_entry_t     issue_alu;
    rs_entry_t     issue_mul;
    rs_entry_t     issue_br;
    rs_entry_t     issue_mem;
    rs_entry_t     issue_v [4];

    // reference model
    logic      launched [MAX_IDS];
    logic      issued   [MAX_IDS];
    op_class_t ent_cls  [MAX_IDS];
    logic      known1   [MAX_IDS];
    logic      known2   [MAX_IDS];
    rob_idx_t  tag1     [MAX_IDS];
    rob_idx_t  tag2     [MAX_IDS];
    word_t     val1     [MAX_IDS];
    word_t     val2     [MAX_IDS];
    logic      tbl_written [ROB_DEPTH];
    word_t     tbl_val     [ROB_DEPTH];
    int        in_station  [4];
    int        outstanding;
    int        next_id;
    logic      stall_seen;
    logic      overtake_seen;
    logic      rand_mode;
    logic [31:0] lcg_state;
    int        errors;
    int        checks;
    int        cycles;

    issue_top uut (.*);

    always_comb begin
        issue_v[0] = issue_alu;
        issue_v[1] = issue_mul;
        issue_v[2] = issue_br;
        issue_v[3] = issue_mem;
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int depth_of(input op_class_t c);
        case (c)
            OPC_ALU: return ALU_RS_DEPTH;
            OPC_MUL: return MUL_RS_DEPTH;
            OPC_BR:  return BR_RS_DEPTH;
            default: return MEM_RS_DEPTH;
        endcase
    endfunction

    // alu port first, then mul, then mem
    function automatic logic broadcast_for(input rob_idx_t t, output word_t v);
        v = '0;
        if (cdb.alu.valid && cdb.alu.rob_idx == t) begin
            v = cdb.alu.data;
            return 1'b1;
        end
        if (cdb.mul.valid && cdb.mul.rob_idx == t) begin
            v = cdb.mul.data;
            return 1'b1;
        end
        if (cdb.mem.valid && cdb.mem.rob_idx == t) begin
            v = cdb.mem.data;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic cdb_port_t rand_port();
        cdb_port_t   p;
        logic [31:0] r;
        r         = rnd();
        p.valid   = r[31] & r[30];
        p.rob_idx = rob_idx_t'(r[29:27] % 7);
        p.data    = rnd();
        return p;
    endfunction

    task automatic expect_true(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Fail at %0t ns: %s", $time, msg);
        end
    endtask

    function automatic int oldest_pending(input op_class_t c);
        for (int i = 0; i < next_id; i++) begin
            if (launched[i] && !issued[i] && ent_cls[i] == c) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_issue(input int c, input rs_entry_t e);
        int id;
        int oldest;
        id = int'(e.imm);
        if (id < 0 || id >= MAX_IDS || !launched[id] || issued[id]) begin
            expect_true(1'b0, $sformatf("issue of unknown or repeated entry %0d", id));
            return;
        end
        expect_true(ent_cls[id] == op_class_t'(c), $sformatf("entry %0d on wrong unit", id));
        expect_true(known1[id] && e.rs1_data == val1[id],
                    $sformatf("entry %0d rs1 got %h expected %h", id, e.rs1_data, val1[id]));
        expect_true(known2[id] && e.rs2_data == val2[id],
                    $sformatf("entry %0d rs2 got %h expected %h", id, e.rs2_data, val2[id]));
        oldest = oldest_pending(op_class_t'(c));
        if (c == OPC_MEM) begin
            expect_true(id == oldest, $sformatf("memory entry %0d issued before %0d", id, oldest));
        end else if (id != oldest) begin
            overtake_seen = 1'b1;
        end
        issued[id] = 1'b1;
        in_station[c]--;
        outstanding--;
    endtask

    task automatic record_dispatch();
        int    id;
        word_t v;
        id          = int'(dispatch.imm);
        launched[id] = 1'b1;
        ent_cls[id] = dispatch.op_class;
        tag1[id]    = dispatch.rs1_rob_idx;
        tag2[id]    = dispatch.rs2_rob_idx;
        known1[id]  = 1'b1;
        known2[id]  = 1'b1;
        if (rs1_ready) begin
            val1[id] = rs1_data;
        end else if (tbl_written[tag1[id]]) begin
            val1[id] = tbl_val[tag1[id]];
        end else begin
            known1[id] = broadcast_for(tag1[id], v);
            val1[id]   = v;
        end
        if (rs2_ready) begin
            val2[id] = rs2_data;
        end else if (tbl_written[tag2[id]]) begin
            val2[id] = tbl_val[tag2[id]];
        end else begin
            known2[id] = broadcast_for(tag2[id], v);
            val2[id]   = v;
        end
        in_station[dispatch.op_class]++;
        outstanding++;
    endtask

    // model runs on the falling edge, ahead of the next rising one
    always @(negedge clk) begin
        word_t v;
        logic  accepted;
        if (!rst) begin
            expect_true(dispatch_stall == (dispatch.valid &&
                        in_station[dispatch.op_class] == depth_of(dispatch.op_class)),
                        "dispatch_stall does not match station occupancy");
            if (dispatch_stall) begin
                stall_seen = 1'b1;
            end
            for (int c = 0; c < 4; c++) begin
                if (issue_v[c].valid && fu_ready[c]) begin
                    check_issue(c, issue_v[c]);
                end
            end
            accepted = dispatch.valid && !dispatch_stall;
            if (accepted) begin
                record_dispatch();
            end
            for (int i = 0; i < next_id; i++) begin
                if (launched[i] && !issued[i]) begin
                    if (!known1[i] && broadcast_for(tag1[i], v)) begin
                        known1[i] = 1'b1;
                        val1[i]   = v;
                    end
                    if (!known2[i] && broadcast_for(tag2[i], v)) begin
                        known2[i] = 1'b1;
                        val2[i]   = v;
                    end
                end
            end
            for (int t = 0; t < ROB_DEPTH; t++) begin
                if (broadcast_for(rob_idx_t'(t), v)) begin
                    tbl_written[t] = 1'b1;
                    tbl_val[t]     = v;
                end else if ((accepted && dispatch.rd_rob_idx == rob_idx_t'(t)) ||
                             (commit_valid && commit_rob_idx == rob_idx_t'(t))) begin
                    tbl_written[t] = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= RUN_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
        cdb          = '0;
        commit_valid = 1'b0;
        if (rand_mode) begin
            cdb.alu        = rand_port();
            cdb.mul        = rand_port();
            cdb.mem        = rand_port();
            fu_ready       = 4'(rnd() >> 28);
            commit_valid   = (rnd() >> 29) == 0;
            commit_rob_idx = rob_idx_t'((rnd() >> 29) % 7);
        end
    endtask

    // tag 7 is the destination of every op and never a source
    task automatic send(input op_class_t cls, input rob_idx_t t1, input logic r1,
                        input word_t d1, input rob_idx_t t2, input logic r2, input word_t d2);
        logic stalled;
        dispatch             = '0;
        dispatch.valid       = 1'b1;
        dispatch.op_class    = cls;
        dispatch.op          = op_code_t'(next_id);
        dispatch.rd_rob_idx  = 3'd7;
        dispatch.rs1_rob_idx = t1;
        dispatch.rs2_rob_idx = t2;
        dispatch.imm         = word_t'(next_id);
        rs1_ready = r1;
        rs1_data  = d1;
        rs2_ready = r2;
        rs2_data  = d2;
        next_id++;
        do begin
            @(negedge clk);
            stalled = dispatch_stall;
            step();
        end while (stalled);
        dispatch.valid = 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0) begin
            step();
        end
    endtask

    task automatic report(input string name, input int errs_before);
        $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int base;
        int id;
        rst = 1'b1;
        dispatch = '0;
        rs1_data = '0;
        rs1_ready = 1'b0;
        rs2_data = '0;
        rs2_ready = 1'b0;
        cdb = '0;
        commit_valid = 1'b0;
        commit_rob_idx = '0;
        fu_ready = 4'hF;
        lcg_state = 32'd31361;
        rand_mode = 1'b0;
        stall_seen = 1'b0;
        overtake_seen = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        outstanding = 0;
        next_id = 0;
        for (int i = 0; i < MAX_IDS; i++) begin
            launched[i] = 1'b0;
            issued[i] = 1'b0;
        end
        for (int t = 0; t < ROB_DEPTH; t++) begin
            tbl_written[t] = 1'b0;
            tbl_val[t] = '0;
        end
        for (int c = 0; c < 4; c++) begin
            in_station[c] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        base = errors;
        repeat (5) begin
            step();
            expect_true(!issue_alu.valid && !issue_mul.valid && !issue_br.valid &&
                        !issue_mem.valid && !dispatch_stall, "activity after reset");
        end
        report("reset", base);

        base = errors;
        send(OPC_ALU, 3'd0, 1'b1, 32'h1111_0000, 3'd0, 1'b1, 32'h2222_0000);
        cdb.alu = '{valid: 1'b1, rob_idx: 3'd1, data: 32'hABCD_0001};
        step();
        send(OPC_MUL, 3'd1, 1'b0, 32'hDEAD_BEEF, 3'd0, 1'b1, 32'h0000_0033);
        drain();
        report("capture", base);

        base = errors;
        id = next_id;
        send(OPC_BR, 3'd2, 1'b0, '0, 3'd3, 1'b0, '0);
        repeat (4) step();
        expect_true(!issued[id], "entry issued before its operands were broadcast");
        cdb.mul = '{valid: 1'b1, rob_idx: 3'd2, data: 32'h0000_2222};
        cdb.mem = '{valid: 1'b1, rob_idx: 3'd3, data: 32'h0000_3333};
        step();
        drain();
        cdb.alu = '{valid: 1'b1, rob_idx: 3'd4, data: 32'h0000_4444};
        send(OPC_ALU, 3'd4, 1'b0, '0, 3'd0, 1'b1, 32'h55);
        drain();
        commit_valid = 1'b1;
        commit_rob_idx = 3'd2;
        step();
        commit_valid = 1'b1;
        commit_rob_idx = 3'd3;
        step();
        report("wakeup", base);

        base = errors;
        fu_ready = 4'b1110;
        fork
            repeat (ALU_RS_DEPTH + 1) begin
                send(OPC_ALU, 3'd0, 1'b1, rnd(), 3'd0, 1'b1, rnd());
            end
            begin
                wait (stall_seen);
                repeat (3) @(posedge clk);
                #1;
                fu_ready = 4'hF;
            end
        join
        drain();
        expect_true(stall_seen, "full station never raised dispatch_stall");
        report("backpressure", base);

        base = errors;
        send(OPC_ALU, 3'd5, 1'b0, '0, 3'd0, 1'b1, 32'h10);
        send(OPC_ALU, 3'd0, 1'b1, 32'h20, 3'd0, 1'b1, 32'h30);
        repeat (3) step();
        cdb.alu = '{valid: 1'b1, rob_idx: 3'd5, data: 32'h0000_5555};
        step();
        drain();
        expect_true(overtake_seen, "younger ready entry did not overtake older waiting one");
        send(OPC_MEM, 3'd6, 1'b0, '0, 3'd0, 1'b1, 32'h40);
        send(OPC_MEM, 3'd0, 1'b1, 32'h50, 3'd0, 1'b1, 32'h60);
        repeat (3) step();
        cdb.mem = '{valid: 1'b1, rob_idx: 3'd6, data: 32'h0000_6666};
        step();
        drain();
        report("ordering", base);

        base = errors;
        rand_mode = 1'b1;
        repeat (RAND_OPS) begin
            send(op_class_t'(rnd() >> 30), rob_idx_t'((rnd() >> 29) % 7), 1'(rnd() >> 31),
                 rnd(), rob_idx_t'((rnd() >> 29) % 7), 1'(rnd() >> 31), rnd());
        end
        rand_mode = 1'b0;
        step();
        fu_ready = 4'hF;
        for (int t = 0; t < 7; t++) begin
            cdb.alu = '{valid: 1'b1, rob_idx: rob_idx_t'(t), data: rnd()};
            step();
        end
        drain();
        report("random", base);

        expect_true(!issue_alu.valid && !issue_mul.valid && !issue_br.valid &&
                    !issue_mem.valid, "entries left in the stations at the end");
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
design/ooo_pkg.sv
design/rob_result_table.sv
design/reservation_station.sv
design/dispatch_issue.sv
design/issue_top.sv
tests/issue_assert.sv
tests/issue_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -f tb.f --top-module issue_tb -Mdir obj_dir

run: compile
	./obj_dir/Vissue_tb > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
